//--- Makefile
# Verilator build and run of the analog signal path testbench

VERILATOR ?= verilator
TOP       ?= tb_pitaya_analog
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "Test passed"; \
	else echo "Test failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
hw/pitaya_sig_pkg.sv
hw/pitaya_regs_pkg.sv
hw/cfg_regs.sv
hw/calib_linear.sv
hw/adc_frontend.sv
hw/dac_backend.sv
hw/pdm_modulator.sv
hw/gpio_debounce.sv
hw/pitaya_analog_top.sv
verif/tb_pitaya_analog.sv

//--- hw/adc_frontend.sv
// ADC input register, code conversion, digital loopback and calibration per channel
`timescale 1ns/1ps

module adc_frontend (
  input  logic                                                adc_clk,
  input  logic                                                top_rst,
  // Converter pins
  input  pitaya_sig_pkg::dac_code_t [pitaya_sig_pkg::N_CH-1:0] adc_dat_i,
  // Loopback
  input  logic [pitaya_sig_pkg::N_CH-1:0]                     loop_sel_i,
  input  pitaya_sig_pkg::sample_t [pitaya_sig_pkg::N_CH-1:0]  dac_smp_i,
  // Calibration
  input  pitaya_sig_pkg::cal_mul_t [pitaya_sig_pkg::N_CH-1:0] mul_i,
  input  pitaya_sig_pkg::cal_sum_t [pitaya_sig_pkg::N_CH-1:0] sum_i,
  // Calibrated samples
  output pitaya_sig_pkg::sample_t [pitaya_sig_pkg::N_CH-1:0]  adc_smp_o
);

  import pitaya_sig_pkg::*;

  sample_t [N_CH-1:0] raw_q;   // Converted input sample
  sample_t [N_CH-1:0] cal_in;  // After loopback mux

  // Input register, should map to IO block flops
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      raw_q <= '0;
    end else begin
      for (int ch = 0; ch < N_CH; ch++) begin
        raw_q[ch] <= code_to_smp(adc_dat_i[ch]);
      end
    end
  end

  for (genvar ch = 0; ch < N_CH; ch++) begin : g_ch

    // Loopback taps the calibrated DAC sample
    assign cal_in[ch] = loop_sel_i[ch] ? dac_smp_i[ch] : raw_q[ch];

    // Gain and offset, 2 cycles
    calib_linear cal_adc (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (cal_in[ch]),
      .mul_i   (mul_i[ch]),
      .sum_i   (sum_i[ch]),
      .smp_o   (adc_smp_o[ch])
    );

  end : g_ch

endmodule : adc_frontend

//--- hw/calib_linear.sv
// Two-stage gain and offset calibration with saturation to the sample range
`timescale 1ns/1ps

module calib_linear (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  // Sample in
  input  pitaya_sig_pkg::sample_t  smp_i,
  // Calibration
  input  pitaya_sig_pkg::cal_mul_t mul_i,
  input  pitaya_sig_pkg::cal_sum_t sum_i,
  // Sample out, two cycles later
  output pitaya_sig_pkg::sample_t  smp_o
);

  import pitaya_sig_pkg::*;

  cal_prd_t prd_q;  // Full-width product
  cal_sum_t sum_q;  // Offset aligned with its product
  cal_acc_t acc;    // Shifted product plus offset

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1, multiply
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      prd_q <= '0;
      sum_q <= '0;
    end else begin
      // Both operands signed, no precision lost
      prd_q <= smp_i * mul_i;
      sum_q <= sum_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 2, scale, offset and clip
  ////////////////////////////////////////////////////////////////////////////

  // Shifted product fits in 16 bits, one extra bit for the add
  assign acc = cal_acc_t'(prd_q >>> CAL_SHIFT) + cal_acc_t'(sum_q);

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      smp_o <= '0;
    end else if (acc > cal_acc_t'(SMP_MAX)) begin
      // Clip high
      smp_o <= SMP_MAX;
    end else if (acc < cal_acc_t'(SMP_MIN)) begin
      // Clip low
      smp_o <= SMP_MIN;
    end else begin
      smp_o <= sample_t'(acc);
    end
  end

endmodule : calib_linear

//--- hw/cfg_regs.sv
// Write-only configuration registers for loopback, calibration, PDM and debounce
`timescale 1ns/1ps

module cfg_regs (
  input  logic                                                 adc_clk,
  input  logic                                                 top_rst,
  // Write port
  input  logic                                                 cfg_we_i,
  input  logic [pitaya_regs_pkg::CFG_AW-1:0]                   cfg_addr_i,
  input  pitaya_regs_pkg::cfg_word_u                           cfg_wdata_i,
  // Settings
  output logic [pitaya_sig_pkg::N_CH-1:0]                      loop_sel_o,
  output pitaya_sig_pkg::cal_mul_t [pitaya_sig_pkg::N_CH-1:0]  adc_mul_o,
  output pitaya_sig_pkg::cal_sum_t [pitaya_sig_pkg::N_CH-1:0]  adc_sum_o,
  output pitaya_sig_pkg::cal_mul_t [pitaya_sig_pkg::N_CH-1:0]  dac_mul_o,
  output pitaya_sig_pkg::cal_sum_t [pitaya_sig_pkg::N_CH-1:0]  dac_sum_o,
  output pitaya_sig_pkg::pdm_lvl_t [pitaya_sig_pkg::PDM_CH-1:0] pdm_lvl_o,
  output logic [pitaya_regs_pkg::DEB_W-1:0]                    deb_len_o
);

  import pitaya_sig_pkg::*;
  import pitaya_regs_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      // Unity gain, no offset, no loopback
      loop_sel_o <= '0;
      for (int ch = 0; ch < N_CH; ch++) begin
        adc_mul_o[ch] <= CAL_UNITY;
        adc_sum_o[ch] <= '0;
        dac_mul_o[ch] <= CAL_UNITY;
        dac_sum_o[ch] <= '0;
      end
      pdm_lvl_o <= '0;
      deb_len_o <= DEB_LEN_RST;
    end else if (cfg_we_i) begin
      // Address picks the view of the write word
      case (cfg_addr_i)
        ADDR_LOOP:     loop_sel_o <= cfg_wdata_i.raw[N_CH-1:0];
        ADDR_ADC_CAL0: begin
          adc_mul_o[0] <= cfg_wdata_i.cal.mul;
          adc_sum_o[0] <= cfg_wdata_i.cal.sum;
        end
        ADDR_ADC_CAL1: begin
          adc_mul_o[1] <= cfg_wdata_i.cal.mul;
          adc_sum_o[1] <= cfg_wdata_i.cal.sum;
        end
        ADDR_DAC_CAL0: begin
          dac_mul_o[0] <= cfg_wdata_i.cal.mul;
          dac_sum_o[0] <= cfg_wdata_i.cal.sum;
        end
        ADDR_DAC_CAL1: begin
          dac_mul_o[1] <= cfg_wdata_i.cal.mul;
          dac_sum_o[1] <= cfg_wdata_i.cal.sum;
        end
        ADDR_PDM:      pdm_lvl_o  <= cfg_wdata_i.pdm;
        ADDR_DEB_LEN:  deb_len_o  <= cfg_wdata_i.raw[DEB_W-1:0];
        // Unmapped address, write dropped
        default: ;
      endcase
    end
  end

endmodule : cfg_regs

//--- hw/dac_backend.sv
// DAC calibration, code conversion and output register per channel
`timescale 1ns/1ps

module dac_backend (
  input  logic                                                 adc_clk,
  input  logic                                                 top_rst,
  // Generator samples
  input  pitaya_sig_pkg::sample_t [pitaya_sig_pkg::N_CH-1:0]   gen_smp_i,
  // Calibration
  input  pitaya_sig_pkg::cal_mul_t [pitaya_sig_pkg::N_CH-1:0]  mul_i,
  input  pitaya_sig_pkg::cal_sum_t [pitaya_sig_pkg::N_CH-1:0]  sum_i,
  // Calibrated samples toward ADC loopback
  output pitaya_sig_pkg::sample_t [pitaya_sig_pkg::N_CH-1:0]   dac_smp_o,
  // Converter pins
  output pitaya_sig_pkg::dac_code_t [pitaya_sig_pkg::N_CH-1:0] dac_dat_o
);

  import pitaya_sig_pkg::*;

  for (genvar ch = 0; ch < N_CH; ch++) begin : g_ch
    // Gain and offset, 2 cycles
    calib_linear cal_dac (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (gen_smp_i[ch]),
      .mul_i   (mul_i[ch]),
      .sum_i   (sum_i[ch]),
      .smp_o   (dac_smp_o[ch])
    );
  end : g_ch

  // Output register, signed to inverted offset binary
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      // Mid-scale code
      for (int ch = 0; ch < N_CH; ch++) begin
        dac_dat_o[ch] <= smp_to_code('0);
      end
    end else begin
      for (int ch = 0; ch < N_CH; ch++) begin
        dac_dat_o[ch] <= smp_to_code(dac_smp_o[ch]);
      end
    end
  end

endmodule : dac_backend

//--- hw/gpio_debounce.sv
// Input synchronizer and debounce counter with rising and falling edge pulses
`timescale 1ns/1ps

module gpio_debounce (
  input  logic                              adc_clk,
  input  logic                              top_rst,
  // Required stable length in cycles
  input  logic [pitaya_regs_pkg::DEB_W-1:0] len_i,
  // Raw pin
  input  logic                              d_i,
  // One-cycle edge pulses
  output logic                              pos_o,
  output logic                              neg_o
);

  import pitaya_regs_pkg::*;

  logic [1:0]       sync_q;   // Bit 1 is the synchronized input
  logic             stb_q;    // Debounced state
  logic [DEB_W-1:0] cnt_q;    // Cycles the input has differed
  logic [DEB_W:0]   cnt_nxt;  // Spare bit so the max length cannot wrap
  logic             flip;

  assign cnt_nxt = {1'b0, cnt_q} + 1'b1;
  // New level held long enough
  assign flip = (sync_q[1] != stb_q) && (cnt_nxt >= {1'b0, len_i});

  ////////////////////////////////////////////////////////////////////////////
  // Synchronizer and stable state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sync_q <= '0;
      stb_q  <= 1'b0;
      cnt_q  <= '0;
      pos_o  <= 1'b0;
      neg_o  <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], d_i};
      // Edge direction follows the new level
      pos_o  <= flip &  sync_q[1];
      neg_o  <= flip & ~sync_q[1];
      if (sync_q[1] == stb_q) begin
        // Glitch ended or input settled, restart
        cnt_q <= '0;
      end else if (flip) begin
        stb_q <= sync_q[1];
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_nxt[DEB_W-1:0];
      end
    end
  end

endmodule : gpio_debounce

//--- hw/pdm_modulator.sv
// Four first-order sigma-delta PDM outputs over a fixed range of 255
`timescale 1ns/1ps

module pdm_modulator (
  input  logic                                                  adc_clk,
  input  logic                                                  top_rst,
  // Levels, one per channel
  input  pitaya_sig_pkg::pdm_lvl_t [pitaya_sig_pkg::PDM_CH-1:0] lvl_i,
  // One-bit outputs
  output logic [pitaya_sig_pkg::PDM_CH-1:0]                     pdm_o
);

  import pitaya_sig_pkg::*;

  // Accumulator stays below PDM_RNG, one guard bit for the add
  logic [PDM_CH-1:0][PDM_W:0] acc_q;
  logic [PDM_CH-1:0][PDM_W:0] acc_sum;

  always_comb begin
    for (int ch = 0; ch < PDM_CH; ch++) begin
      acc_sum[ch] = acc_q[ch] + {1'b0, lvl_i[ch]};
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      acc_q <= '0;
      pdm_o <= '0;
    end else begin
      for (int ch = 0; ch < PDM_CH; ch++) begin
        if (acc_sum[ch] >= {1'b0, PDM_RNG}) begin
          // Overflow, emit a one and keep the residue
          acc_q[ch] <= acc_sum[ch] - {1'b0, PDM_RNG};
          pdm_o[ch] <= 1'b1;
        end else begin
          acc_q[ch] <= acc_sum[ch];
          pdm_o[ch] <= 1'b0;
        end
      end
    end
  end

endmodule : pdm_modulator

//--- hw/pitaya_analog_top.sv
// Analog signal path top level with configuration, ADC, DAC, PDM and trigger debounce
`timescale 1ns/1ps

module pitaya_analog_top (
  input  logic                                                 adc_clk,
  input  logic                                                 top_rst,
  // Configuration write port
  input  logic                                                 cfg_we_i,
  input  logic [pitaya_regs_pkg::CFG_AW-1:0]                   cfg_addr_i,
  input  pitaya_regs_pkg::cfg_word_u                           cfg_wdata_i,
  // ADC pins and samples
  input  pitaya_sig_pkg::dac_code_t [pitaya_sig_pkg::N_CH-1:0] adc_dat_i,
  output pitaya_sig_pkg::sample_t [pitaya_sig_pkg::N_CH-1:0]   adc_smp_o,
  // Generator samples and DAC pins
  input  pitaya_sig_pkg::sample_t [pitaya_sig_pkg::N_CH-1:0]   gen_smp_i,
  output pitaya_sig_pkg::dac_code_t [pitaya_sig_pkg::N_CH-1:0] dac_dat_o,
  // PDM analog outputs
  output logic [pitaya_sig_pkg::PDM_CH-1:0]                    pdm_o,
  // Expansion trigger
  input  logic                                                 exp_trg_i,
  output logic                                                 gio_pos_o,
  output logic                                                 gio_neg_o
);

  import pitaya_sig_pkg::*;
  import pitaya_regs_pkg::*;

  logic [N_CH-1:0]      loop_sel;
  cal_mul_t [N_CH-1:0]  adc_mul;
  cal_sum_t [N_CH-1:0]  adc_sum;
  cal_mul_t [N_CH-1:0]  dac_mul;
  cal_sum_t [N_CH-1:0]  dac_sum;
  pdm_lvl_t [PDM_CH-1:0] pdm_lvl;
  logic [DEB_W-1:0]     deb_len;
  sample_t [N_CH-1:0]   dac_smp;  // Calibrated DAC samples for loopback

  ////////////////////////////////////////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////////////////////////////////////////

  cfg_regs cfg_regs (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .loop_sel_o  (loop_sel),
    .adc_mul_o   (adc_mul),
    .adc_sum_o   (adc_sum),
    .dac_mul_o   (dac_mul),
    .dac_sum_o   (dac_sum),
    .pdm_lvl_o   (pdm_lvl),
    .deb_len_o   (deb_len)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Analog data path
  ////////////////////////////////////////////////////////////////////////////

  adc_frontend adc_frontend (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat_i),
    .loop_sel_i (loop_sel),
    .dac_smp_i  (dac_smp),
    .mul_i      (adc_mul),
    .sum_i      (adc_sum),
    .adc_smp_o  (adc_smp_o)
  );

  dac_backend dac_backend (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .gen_smp_i (gen_smp_i),
    .mul_i     (dac_mul),
    .sum_i     (dac_sum),
    .dac_smp_o (dac_smp),
    .dac_dat_o (dac_dat_o)
  );

  // Slow analog outputs
  pdm_modulator pdm_modulator (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .lvl_i   (pdm_lvl),
    .pdm_o   (pdm_o)
  );

  // Expansion connector trigger
  gpio_debounce gpio_debounce (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .len_i   (deb_len),
    .d_i     (exp_trg_i),
    .pos_o   (gio_pos_o),
    .neg_o   (gio_neg_o)
  );

endmodule : pitaya_analog_top

//--- hw/pitaya_regs_pkg.sv
// Register map, reset values and decoded write word of the configuration block
package pitaya_regs_pkg;

  // Write port geometry
  localparam int unsigned CFG_AW = 3;
  localparam int unsigned CFG_DW = 32;

  // Register addresses
  localparam logic [CFG_AW-1:0] ADDR_LOOP     = 3'd0;  // Loopback select per channel
  localparam logic [CFG_AW-1:0] ADDR_ADC_CAL0 = 3'd1;
  localparam logic [CFG_AW-1:0] ADDR_ADC_CAL1 = 3'd2;
  localparam logic [CFG_AW-1:0] ADDR_DAC_CAL0 = 3'd3;
  localparam logic [CFG_AW-1:0] ADDR_DAC_CAL1 = 3'd4;
  localparam logic [CFG_AW-1:0] ADDR_PDM      = 3'd5;  // Byte n is PDM channel n
  localparam logic [CFG_AW-1:0] ADDR_DEB_LEN  = 3'd6;
  // Address 7 is unmapped

  // Debounce counter
  localparam int unsigned      DEB_W       = 20;
  localparam logic [DEB_W-1:0] DEB_LEN_RST = 20'd62500;  // 0.5 ms at 125 MHz

  // Calibration word layout, gain on top
  typedef struct packed {
    pitaya_sig_pkg::cal_mul_t mul;
    logic [1:0]               rsv;
    pitaya_sig_pkg::cal_sum_t sum;
  } cal_word_t;

  // One write word, three views chosen by address
  typedef union packed {
    cal_word_t                                            cal;
    pitaya_sig_pkg::pdm_lvl_t [pitaya_sig_pkg::PDM_CH-1:0] pdm;
    logic [CFG_DW-1:0]                                     raw;
  } cfg_word_u;

endpackage : pitaya_regs_pkg

//--- hw/pitaya_sig_pkg.sv
// Sample, calibration and PDM types shared by the analog data path
package pitaya_sig_pkg;

  // Channel counts
  localparam int unsigned N_CH   = 2;
  localparam int unsigned PDM_CH = 4;

  // Sample format, two's complement
  localparam int unsigned SMP_W = 14;
  typedef logic signed [SMP_W-1:0] sample_t;
  // Converter pin code, inverted offset binary (ADC and DAC alike)
  typedef logic        [SMP_W-1:0] dac_code_t;

  // Saturation limits
  localparam sample_t SMP_MAX = {1'b0, {(SMP_W-1){1'b1}}};
  localparam sample_t SMP_MIN = {1'b1, {(SMP_W-1){1'b0}}};

  // Gain is Q2.14, offset in sample units
  localparam int unsigned CAL_W     = 16;
  localparam int unsigned CAL_SHIFT = 14;
  typedef logic signed [CAL_W-1:0] cal_mul_t;
  typedef logic signed [SMP_W-1:0] cal_sum_t;
  localparam cal_mul_t CAL_UNITY = 16'sd16384;

  // Full product, then shifted product plus offset with one guard bit
  typedef logic signed [SMP_W+CAL_W-1:0]         cal_prd_t;
  typedef logic signed [SMP_W+CAL_W-CAL_SHIFT:0] cal_acc_t;

  // PDM level over a fixed range
  localparam int unsigned PDM_W = 8;
  typedef logic [PDM_W-1:0] pdm_lvl_t;
  localparam pdm_lvl_t PDM_RNG = 8'd255;

  // Pin code to sample: top bit kept, rest inverted
  function automatic sample_t code_to_smp(dac_code_t code);
    return {code[SMP_W-1], ~code[SMP_W-2:0]};
  endfunction

  // Sample to pin code, same bit flip in the other direction
  function automatic dac_code_t smp_to_code(sample_t smp);
    return {smp[SMP_W-1], ~smp[SMP_W-2:0]};
  endfunction

endpackage : pitaya_sig_pkg

//--- verif/tb_pitaya_analog.sv
// Self-checking testbench for the analog signal path top level
`timescale 1ns/1ps

module tb_pitaya_analog;

  import pitaya_sig_pkg::*;
  import pitaya_regs_pkg::*;

  localparam int unsigned SEED     = 32'h94511f53;
  localparam longint      SMP_HI   = 8191;
  localparam longint      SMP_LO   = -8192;
  localparam dac_code_t   LOW_MASK = 14'h1fff;  // Every bit below the sign

  logic                 adc_clk;
  logic                 top_rst;
  logic                 cfg_we_i;
  logic [CFG_AW-1:0]    cfg_addr_i;
  cfg_word_u            cfg_wdata_i;
  dac_code_t [N_CH-1:0] adc_dat_i;
  sample_t [N_CH-1:0]   gen_smp_i;
  logic                 exp_trg_i;
  sample_t [N_CH-1:0]   adc_smp_o;
  dac_code_t [N_CH-1:0] dac_dat_o;
  logic [PDM_CH-1:0]    pdm_o;
  logic                 gio_pos_o;
  logic                 gio_neg_o;

  // Model of the configuration registers
  cal_mul_t        adc_mul_m [N_CH];
  cal_sum_t        adc_sum_m [N_CH];
  cal_mul_t        dac_mul_m [N_CH];
  cal_sum_t        dac_sum_m [N_CH];
  logic [N_CH-1:0] loop_m;
  logic            run_chk;  // Low while config settles

  // Expected outputs, one entry per cycle, newest at the back
  sample_t [N_CH-1:0]   adc_q [$];
  sample_t [N_CH-1:0]   lpb_q [$];
  dac_code_t [N_CH-1:0] dac_q [$];

  pitaya_analog_top dut0 (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .adc_dat_i   (adc_dat_i),
    .adc_smp_o   (adc_smp_o),
    .gen_smp_i   (gen_smp_i),
    .dac_dat_o   (dac_dat_o),
    .pdm_o       (pdm_o),
    .exp_trg_i   (exp_trg_i),
    .gio_pos_o   (gio_pos_o),
    .gio_neg_o   (gio_neg_o)
  );

  // 50 MHz
  initial begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Offset binary with inverted magnitude bits
  function automatic sample_t adc_conv(dac_code_t code);
    return sample_t'(code ^ LOW_MASK);
  endfunction

  function automatic dac_code_t dac_code(sample_t smp);
    return dac_code_t'(smp) ^ LOW_MASK;
  endfunction

  // Gain in Q2.14, floor shift, offset, clip
  function automatic sample_t cal_ref(sample_t smp, cal_mul_t mul, cal_sum_t sum);
    longint v;
    v = (longint'(smp) * longint'(mul)) >>> CAL_SHIFT;
    v = v + longint'(sum);
    if (v > SMP_HI) begin
      v = SMP_HI;
    end else if (v < SMP_LO) begin
      v = SMP_LO;
    end
    return sample_t'(v);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      fail_stop($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_code(input string name, input dac_code_t got, input dac_code_t exp);
    if (got !== exp) begin
      fail_stop($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_stop($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      fail_stop($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  // Record inputs each cycle, compare outputs 3 or 4 entries back
  always @(negedge adc_clk) begin
    sample_t [N_CH-1:0]   e_adc;
    sample_t [N_CH-1:0]   e_lpb;
    dac_code_t [N_CH-1:0] e_dac;
    sample_t              d_cal;
    if (!run_chk) begin
      adc_q.delete();
      lpb_q.delete();
      dac_q.delete();
    end else begin
      for (int ch = 0; ch < N_CH; ch++) begin
        d_cal     = cal_ref(gen_smp_i[ch], dac_mul_m[ch], dac_sum_m[ch]);
        e_adc[ch] = cal_ref(adc_conv(adc_dat_i[ch]), adc_mul_m[ch], adc_sum_m[ch]);
        e_lpb[ch] = cal_ref(d_cal, adc_mul_m[ch], adc_sum_m[ch]);
        e_dac[ch] = dac_code(d_cal);
      end
      adc_q.push_back(e_adc);
      lpb_q.push_back(e_lpb);
      dac_q.push_back(e_dac);
      if (adc_q.size() > 5) begin
        void'(adc_q.pop_front());
        void'(lpb_q.pop_front());
        void'(dac_q.pop_front());
      end
      // Index 4 is this cycle
      if (adc_q.size() == 5) begin
        for (int ch = 0; ch < N_CH; ch++) begin
          if (loop_m[ch]) begin
            check_sample($sformatf("adc_smp_o[%0d]", ch), adc_smp_o[ch], lpb_q[0][ch]);
          end else begin
            check_sample($sformatf("adc_smp_o[%0d]", ch), adc_smp_o[ch], adc_q[1][ch]);
          end
          check_code($sformatf("dac_dat_o[%0d]", ch), dac_dat_o[ch], dac_q[1][ch]);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Fresh random samples every cycle
  always @(posedge adc_clk) begin
    for (int ch = 0; ch < N_CH; ch++) begin
      adc_dat_i[ch] <= dac_code_t'($urandom);
      gen_smp_i[ch] <= sample_t'($urandom);
    end
  end

  // One write, then let the pipelines fill with the new setting
  task automatic write_cfg(input logic [CFG_AW-1:0] addr, input logic [CFG_DW-1:0] data);
    @(posedge adc_clk);
    run_chk = 1'b0;
    cfg_we_i        <= 1'b1;
    cfg_addr_i      <= addr;
    cfg_wdata_i.raw <= data;
    @(posedge adc_clk);
    cfg_we_i <= 1'b0;
    repeat (3) @(posedge adc_clk);
  endtask

  task automatic set_adc_cal(input int ch, input cal_mul_t mul, input cal_sum_t sum);
    write_cfg((ch == 0) ? ADDR_ADC_CAL0 : ADDR_ADC_CAL1, {mul, 2'b00, sum});
    adc_mul_m[ch] = mul;
    adc_sum_m[ch] = sum;
    run_chk = 1'b1;
  endtask

  task automatic set_dac_cal(input int ch, input cal_mul_t mul, input cal_sum_t sum);
    write_cfg((ch == 0) ? ADDR_DAC_CAL0 : ADDR_DAC_CAL1, {mul, 2'b00, sum});
    dac_mul_m[ch] = mul;
    dac_sum_m[ch] = sum;
    run_chk = 1'b1;
  endtask

  task automatic set_loop(input logic [N_CH-1:0] sel);
    write_cfg(ADDR_LOOP, {{(CFG_DW-N_CH){1'b0}}, sel});
    loop_m  = sel;
    run_chk = 1'b1;
  endtask

  // Bounded watch of the trigger pulses, first index -1 if none
  task automatic count_pulses(input int ncyc, output int npos, output int nneg,
                              output int first_pos, output int first_neg);
    npos      = 0;
    nneg      = 0;
    first_pos = -1;
    first_neg = -1;
    for (int i = 0; i < ncyc; i++) begin
      @(negedge adc_clk);
      if (gio_pos_o) begin
        if (npos == 0) first_pos = i;
        npos++;
      end
      if (gio_neg_o) begin
        if (nneg == 0) first_neg = i;
        nneg++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int                    npos;
    int                    nneg;
    int                    fpos;
    int                    fneg;
    int                    len;
    int                    sel;
    int                    ones [PDM_CH];
    pdm_lvl_t [PDM_CH-1:0] lv;
    void'($urandom(SEED));
    top_rst     = 1'b1;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    adc_dat_i   = '0;
    gen_smp_i   = '0;
    exp_trg_i   = 1'b0;
    run_chk     = 1'b0;
    loop_m      = '0;
    for (int ch = 0; ch < N_CH; ch++) begin
      adc_mul_m[ch] = CAL_UNITY;
      adc_sum_m[ch] = '0;
      dac_mul_m[ch] = CAL_UNITY;
      dac_sum_m[ch] = '0;
    end

    // Reset for 5 cycles, idle outputs checked before release
    repeat (4) @(posedge adc_clk);
    @(negedge adc_clk);
    for (int ch = 0; ch < N_CH; ch++) begin
      check_sample($sformatf("adc_smp_o[%0d]", ch), adc_smp_o[ch], '0);
      check_code($sformatf("dac_dat_o[%0d]", ch), dac_dat_o[ch], dac_code('0));
    end
    @(posedge adc_clk);
    top_rst <= 1'b0;
    @(posedge adc_clk);
    run_chk = 1'b1;

    // Defaults, unity path with quiet PDM and trigger
    for (int i = 0; i < 100; i++) begin
      @(negedge adc_clk);
      for (int p = 0; p < PDM_CH; p++) begin
        check_bit($sformatf("pdm_o[%0d]", p), pdm_o[p], 1'b0);
      end
      check_bit("gio_pos_o", gio_pos_o, 1'b0);
      check_bit("gio_neg_o", gio_neg_o, 1'b0);
    end

    // ADC calibration, full-range gains saturate often
    for (int r = 0; r < 3; r++) begin
      for (int ch = 0; ch < N_CH; ch++) begin
        set_adc_cal(ch, cal_mul_t'($urandom), cal_sum_t'($urandom));
      end
      repeat (150) @(posedge adc_clk);
    end

    // Unmapped address must change nothing
    write_cfg(3'd7, $urandom);
    run_chk = 1'b1;
    repeat (50) @(posedge adc_clk);

    // DAC calibration
    for (int r = 0; r < 3; r++) begin
      for (int ch = 0; ch < N_CH; ch++) begin
        set_dac_cal(ch, cal_mul_t'($urandom), cal_sum_t'($urandom));
      end
      repeat (150) @(posedge adc_clk);
    end

    // Loopback on one channel only
    sel = int'($urandom_range(0, N_CH - 1));
    set_loop((sel == 0) ? 2'b01 : 2'b10);
    repeat (200) @(posedge adc_clk);
    set_loop('0);
    repeat (50) @(posedge adc_clk);

    // PDM density over one full range window
    for (int p = 0; p < PDM_CH; p++) begin
      lv[p] = pdm_lvl_t'($urandom);
      ones[p] = 0;
    end
    write_cfg(ADDR_PDM, lv);
    run_chk = 1'b1;
    repeat (300) @(posedge adc_clk);
    repeat (PDM_RNG) begin
      @(negedge adc_clk);
      for (int p = 0; p < PDM_CH; p++) begin
        if (pdm_o[p]) ones[p]++;
      end
    end
    for (int p = 0; p < PDM_CH; p++) begin
      check_count($sformatf("pdm_o[%0d] ones", p), ones[p], int'(lv[p]));
    end

    // Debounce, glitches up to 15 cycles stay silent
    write_cfg(ADDR_DEB_LEN, 32'd16);
    run_chk = 1'b1;
    for (int g = 0; g < 6; g++) begin
      len = (g == 0) ? 15 : int'($urandom_range(1, 15));
      @(posedge adc_clk);
      exp_trg_i <= 1'b1;
      repeat (len) @(posedge adc_clk);
      exp_trg_i <= 1'b0;
      count_pulses(25, npos, nneg, fpos, fneg);
      check_count("gio_pos_o pulses after glitch", npos, 0);
      check_count("gio_neg_o pulses after glitch", nneg, 0);
    end

    // Held rise, then held fall
    @(posedge adc_clk);
    exp_trg_i <= 1'b1;
    count_pulses(40, npos, nneg, fpos, fneg);
    check_count("gio_pos_o pulses after rise", npos, 1);
    check_count("gio_neg_o pulses after rise", nneg, 0);
    if (fpos >= 20) fail_stop("Rising trigger pulse came later than 20 cycles");
    @(posedge adc_clk);
    exp_trg_i <= 1'b0;
    count_pulses(40, npos, nneg, fpos, fneg);
    check_count("gio_neg_o pulses after fall", nneg, 1);
    check_count("gio_pos_o pulses after fall", npos, 0);
    if (fneg >= 20) fail_stop("Falling trigger pulse came later than 20 cycles");

    $display("Done: no errors");
    $finish;
  end

endmodule : tb_pitaya_analog
